//--- core_pkg.sv
package core_pkg;

    // Reorder-buffer and register-file identifiers
    typedef logic [5:0] t_robid;
    typedef logic [5:0] t_prf_id;

    typedef logic [31:0] t_rv_reg_data;

    // Completion report back to the ROB
    typedef struct packed {
        logic   valid;
        t_robid robid;
    } t_rob_complete_pkt;

    // Register-file write port packet
    typedef struct packed {
        t_prf_id      pdst;
        t_rv_reg_data data;
    } t_prf_wr_pkt;

endpackage

//--- mem_pkg.sv
package mem_pkg;
    import core_pkg::*;

    // Cache geometry
    localparam int L1_NUM_WAYS   = 2;
    localparam int L1_NUM_SETS   = 4;
    localparam int L1_LINE_BYTES = 16;
    localparam int L1_LINE_WORDS = 4;

    // Address fields
    localparam int L1_OFFSET_LO = 0;
    localparam int L1_OFFSET_HI = 3;
    localparam int L1_SET_LO    = 4;
    localparam int L1_SET_HI    = 5;
    localparam int L1_TAG_LO    = 6;
    localparam int L1_TAG_HI    = 15;

    // MM0 through MM5
    localparam int NUM_MM_STAGES = 6;

    typedef logic [15:0]                        t_paddr;
    typedef logic [L1_TAG_HI-L1_TAG_LO:0]       t_l1_tag;
    typedef logic [L1_SET_HI-L1_SET_LO:0]       t_l1_set_addr;
    typedef logic [$clog2(L1_NUM_WAYS)-1:0]     t_l1_way;
    typedef logic [L1_OFFSET_HI-L1_OFFSET_LO:0] t_cl_offset;

    // Invalid encodes as zero so a cleared state array reads as I
    typedef enum logic [1:0] {
        MESI_I = 2'd0,
        MESI_S = 2'd1,
        MESI_E = 2'd2,
        MESI_M = 2'd3
    } t_mesi;

    typedef enum logic [1:0] {
        MEM_LOAD  = 2'd0,
        MEM_STORE = 2'd1,
        MEM_FILL  = 2'd2
    } t_mem_kind;

    // Cache line, filled by words and read by bytes
    typedef union packed {
        logic [L1_LINE_BYTES-1:0][7:0] b;
        logic [L1_LINE_WORDS-1:0][31:0] w;
    } t_cl;

    // Request travelling down the pipe
    typedef struct packed {
        t_mem_kind    kind;
        t_paddr       addr;
        t_l1_way      way;
        t_cl          line;
        t_rv_reg_data st_data;
        t_robid       robid;
        t_prf_id      pdst;
    } t_mempipe_arb;

    typedef struct packed {
        logic complete;
        logic recycle;
    } t_mempipe_action;

endpackage

//--- l1_arrays.sv
`timescale 1ns/100ps

module l1_arrays import mem_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,

    input  t_l1_set_addr                set_addr_mm1,
    input  logic                        rd_en_mm1,
    input  logic                        fill_en_mm1,
    input  t_l1_way                     fill_way_mm1,
    input  t_l1_tag                     fill_tag_mm1,
    input  t_cl                         fill_line_mm1,

    input  logic                        st_wr_en_mm5,
    input  t_l1_set_addr                st_set_mm5,
    input  t_l1_way                     st_way_mm5,
    input  t_cl                         st_line_mm5,

    output t_l1_tag [L1_NUM_WAYS-1:0]   tag_rd_ways_mm2,
    output t_mesi [L1_NUM_WAYS-1:0]     state_rd_ways_mm2,
    output t_cl [L1_NUM_WAYS-1:0]       data_rd_ways_mm2
);

    t_l1_tag tag_q   [L1_NUM_SETS][L1_NUM_WAYS];
    t_mesi   state_q [L1_NUM_SETS][L1_NUM_WAYS];
    t_cl     line_q  [L1_NUM_SETS][L1_NUM_WAYS];

    // Line states; the store write comes last so it wins a same-entry clash
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < L1_NUM_SETS; s++) begin
                for (int w = 0; w < L1_NUM_WAYS; w++) begin
                    state_q[s][w] <= MESI_I;
                end
            end
        end else begin
            if (fill_en_mm1) begin
                state_q[set_addr_mm1][fill_way_mm1] <= MESI_E;
            end
            if (st_wr_en_mm5) begin
                state_q[st_set_mm5][st_way_mm5] <= MESI_M;
            end
        end
    end

    // Tags and line data
    always_ff @(posedge clk) begin
        if (fill_en_mm1) begin
            tag_q[set_addr_mm1][fill_way_mm1]  <= fill_tag_mm1;
            line_q[set_addr_mm1][fill_way_mm1] <= fill_line_mm1;
        end
        if (st_wr_en_mm5) begin
            line_q[st_set_mm5][st_way_mm5] <= st_line_mm5;
        end
    end

    // All ways of the set, one cycle after the MM1 read
    always_ff @(posedge clk) begin
        if (rd_en_mm1) begin
            for (int w = 0; w < L1_NUM_WAYS; w++) begin
                tag_rd_ways_mm2[w]   <= tag_q[set_addr_mm1][w];
                state_rd_ways_mm2[w] <= state_q[set_addr_mm1][w];
                data_rd_ways_mm2[w]  <= line_q[set_addr_mm1][w];
            end
        end
    end

endmodule

//--- fill_queue.sv
`timescale 1ns/100ps

module fill_queue import mem_pkg::*; #(
    parameter int FLQ_ENTRIES = 2
) (
    input  logic         clk,
    input  logic         rst_n,

    input  logic         valid_mm1,
    input  t_mempipe_arb req_pkt_mm1,
    output logic         flq_addr_mat_mm2,

    input  logic         flq_alloc_mm5,
    input  t_paddr       req_addr_mm5,

    output logic         fl_req,
    output t_mempipe_arb fl_req_pkt,
    input  logic         fl_gnt,

    output logic         wb_cyc,
    output logic         wb_stb,
    output logic [13:0]  wb_adr,
    input  logic         wb_ack,
    input  logic [31:0]  wb_dat_i
);

    localparam int PTR_W  = (FLQ_ENTRIES > 1) ? $clog2(FLQ_ENTRIES) : 1;
    localparam int LA_W   = L1_TAG_HI - L1_SET_LO + 1;
    localparam int BEAT_W = $clog2(L1_LINE_WORDS);

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_REQ,
        WB_GAP,
        WB_DONE
    } t_wb_state;

    logic [FLQ_ENTRIES-1:0] ent_valid;
    logic [LA_W-1:0]        ent_addr [FLQ_ENTRIES];
    logic [PTR_W-1:0]       head;
    logic [PTR_W-1:0]       tail;
    logic [FLQ_ENTRIES-1:0] cam_mm1;
    logic [FLQ_ENTRIES-1:0] cam_mm5;
    logic                   alloc_ok;
    logic                   fill_done;

    t_wb_state              wb_state;
    logic [BEAT_W-1:0]      beat;
    t_cl                    fill_line;
    t_l1_way                victim;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(FLQ_ENTRIES - 1)) ? '0 : p + 1'b1;
    endfunction

    // Line-address CAM, for the MM1 lookup and the MM5 allocation
    always_comb begin
        for (int e = 0; e < FLQ_ENTRIES; e++) begin
            cam_mm1[e] = ent_valid[e] & (ent_addr[e] == req_pkt_mm1.addr[L1_TAG_HI:L1_SET_LO]);
            cam_mm5[e] = ent_valid[e] & (ent_addr[e] == req_addr_mm5[L1_TAG_HI:L1_SET_LO]);
        end
    end

    // Back-to-back misses to one line both pass the MM1 lookup
    assign alloc_ok  = flq_alloc_mm5 & ~ent_valid[tail] & ~|cam_mm5;
    assign fill_done = fl_req & fl_gnt;

    // Entries are kept in age order, oldest at head
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ent_valid        <= '0;
            head             <= '0;
            tail             <= '0;
            flq_addr_mat_mm2 <= 1'b0;
        end else begin
            flq_addr_mat_mm2 <= valid_mm1 & |cam_mm1;
            if (alloc_ok) begin
                ent_valid[tail] <= 1'b1;
                tail            <= ptr_inc(tail);
            end
            if (fill_done) begin
                ent_valid[head] <= 1'b0;
                head            <= ptr_inc(head);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_ok) begin
            ent_addr[tail] <= req_addr_mm5[L1_TAG_HI:L1_SET_LO];
        end
    end

    // Wishbone read of the head line, one idle strobe cycle between beats
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_state <= WB_IDLE;
            beat     <= '0;
            victim   <= '0;
        end else begin
            case (wb_state)
                WB_IDLE: begin
                    if (ent_valid[head]) begin
                        wb_state <= WB_REQ;
                        beat     <= '0;
                    end
                end
                WB_REQ: begin
                    if (wb_ack) begin
                        beat     <= beat + 1'b1;
                        wb_state <= (beat == BEAT_W'(L1_LINE_WORDS - 1)) ? WB_DONE : WB_GAP;
                    end
                end
                WB_GAP: begin
                    wb_state <= WB_REQ;
                end
                default: begin
                    if (fl_gnt) begin
                        wb_state <= WB_IDLE;
                        victim   <= victim + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wb_state == WB_REQ && wb_ack) begin
            fill_line.w[beat] <= wb_dat_i;
        end
    end

    assign wb_cyc = (wb_state == WB_REQ) || (wb_state == WB_GAP);
    assign wb_stb = (wb_state == WB_REQ);
    assign wb_adr = {ent_addr[head], beat};
    assign fl_req = (wb_state == WB_DONE);

    // Fill request into the pipe
    always_comb begin
        fl_req_pkt      = '0;
        fl_req_pkt.kind = MEM_FILL;
        fl_req_pkt.addr = {ent_addr[head], {L1_SET_LO{1'b0}}};
        fl_req_pkt.way  = victim;
        fl_req_pkt.line = fill_line;
    end

endmodule

//--- mempipe.sv
`timescale 1ns/100ps

module mempipe import core_pkg::*, mem_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        ld_req,
    input  t_mempipe_arb                ld_req_pkt,
    output logic                        ld_gnt,
    input  logic                        st_req,
    input  t_mempipe_arb                st_req_pkt,
    output logic                        st_gnt,
    input  logic                        fl_req,
    input  t_mempipe_arb                fl_req_pkt,
    output logic                        fl_gnt,

    output t_l1_set_addr                set_addr_mm1,
    output logic                        rd_en_mm1,
    output logic                        fill_en_mm1,
    output t_l1_way                     fill_way_mm1,
    output t_l1_tag                     fill_tag_mm1,
    output t_cl                         fill_line_mm1,
    input  t_l1_tag [L1_NUM_WAYS-1:0]   tag_rd_ways_mm2,
    input  t_mesi [L1_NUM_WAYS-1:0]     state_rd_ways_mm2,
    input  t_cl [L1_NUM_WAYS-1:0]       data_rd_ways_mm2,

    // Fill-queue CAM
    output logic                        valid_mm1,
    output t_mempipe_arb                req_pkt_mm1,
    input  logic                        flq_addr_mat_mm2,

    output logic                        st_wr_en_mm5,
    output t_l1_set_addr                st_set_mm5,
    output t_l1_way                     st_way_mm5,
    output t_cl                         st_line_mm5,

    output logic                        flq_alloc_mm5,
    output t_paddr                      req_addr_mm5,

    output logic                        valid_mm5,
    output t_mempipe_action             action_mm5,
    output t_rob_complete_pkt           complete_mm5,
    output logic                        prf_wr_en_mm5,
    output t_prf_wr_pkt                 prf_wr_pkt_mm5
);

    // Stage registers, index is the MM stage number
    logic [NUM_MM_STAGES-1:0] valid_q;
    t_mempipe_arb             pkt_q [NUM_MM_STAGES];

    logic                     valid_arb;
    t_mempipe_arb             pkt_arb;

    logic [L1_NUM_WAYS-1:0]   hit_vec_mm2;
    logic [L1_NUM_WAYS-1:0]   hit_vec_mm3;
    t_cl [L1_NUM_WAYS-1:0]    data_ways_mm3;
    logic                     mat_mm3;
    t_cl                      line_mm3;
    t_l1_way                  way_mm3;

    t_cl                      line_mm4;
    t_l1_way                  way_mm4;
    logic                     hit_mm4;
    logic                     mat_mm4;
    t_rv_reg_data             rot_mm4;

    t_cl                      line_mm5;
    t_l1_way                  way_mm5;
    logic                     hit_mm5;
    logic                     mat_mm5;
    t_rv_reg_data             rot_mm5;
    logic                     is_ld_mm5;
    logic                     is_st_mm5;
    logic                     is_fl_mm5;

    // MM0 fixed priority: load, store, fill
    always_comb begin
        ld_gnt    = ld_req;
        st_gnt    = st_req & ~ld_req;
        fl_gnt    = fl_req & ~ld_req & ~st_req;
        valid_arb = ld_req | st_req | fl_req;
        if (ld_req) begin
            pkt_arb = ld_req_pkt;
        end else if (st_req) begin
            pkt_arb = st_req_pkt;
        end else begin
            pkt_arb = fl_req_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[NUM_MM_STAGES-2:0], valid_arb};
        end
    end

    always_ff @(posedge clk) begin
        pkt_q[0] <= pkt_arb;
        for (int s = 1; s < NUM_MM_STAGES; s++) begin
            pkt_q[s] <= pkt_q[s-1];
        end
    end

    // MM1: array access, no TLB
    assign valid_mm1     = valid_q[1];
    assign req_pkt_mm1   = pkt_q[1];
    assign set_addr_mm1  = pkt_q[1].addr[L1_SET_HI:L1_SET_LO];
    assign rd_en_mm1     = valid_q[1] & (pkt_q[1].kind inside {MEM_LOAD, MEM_STORE});
    assign fill_en_mm1   = valid_q[1] & (pkt_q[1].kind == MEM_FILL);
    assign fill_way_mm1  = pkt_q[1].way;
    assign fill_tag_mm1  = pkt_q[1].addr[L1_TAG_HI:L1_TAG_LO];
    assign fill_line_mm1 = pkt_q[1].line;

    // MM2: per-way hit; stores need write permission
    always_comb begin
        for (int w = 0; w < L1_NUM_WAYS; w++) begin
            hit_vec_mm2[w] = valid_q[2]
                & (tag_rd_ways_mm2[w] == pkt_q[2].addr[L1_TAG_HI:L1_TAG_LO])
                & ((pkt_q[2].kind == MEM_LOAD)
                       & (state_rd_ways_mm2[w] inside {MESI_M, MESI_E, MESI_S})
                 | (pkt_q[2].kind == MEM_STORE)
                       & (state_rd_ways_mm2[w] inside {MESI_M, MESI_E}));
        end
    end

    always_ff @(posedge clk) begin
        hit_vec_mm3   <= hit_vec_mm2;
        data_ways_mm3 <= data_rd_ways_mm2;
        mat_mm3       <= flq_addr_mat_mm2;
    end

    // MM3: AND-OR way mux
    always_comb begin
        line_mm3 = '0;
        way_mm3  = '0;
        for (int w = 0; w < L1_NUM_WAYS; w++) begin
            line_mm3 = line_mm3 | ({$bits(t_cl){hit_vec_mm3[w]}} & data_ways_mm3[w]);
            if (hit_vec_mm3[w]) begin
                way_mm3 = t_l1_way'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        line_mm4 <= line_mm3;
        way_mm4  <= way_mm3;
        hit_mm4  <= |hit_vec_mm3;
        mat_mm4  <= mat_mm3;
    end

    // MM4: four bytes from the offset, wrapping inside the line
    always_comb begin
        t_cl_offset o;
        o       = pkt_q[4].addr[L1_OFFSET_HI:L1_OFFSET_LO];
        rot_mm4 = '0;
        for (int b = 0; b < 4; b++) begin
            rot_mm4[8*b +: 8] = line_mm4.b[o];
            o = o + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        line_mm5 <= line_mm4;
        way_mm5  <= way_mm4;
        hit_mm5  <= hit_mm4;
        mat_mm5  <= mat_mm4;
        rot_mm5  <= rot_mm4;
    end

    // MM5: result and action
    assign valid_mm5    = valid_q[5];
    assign is_ld_mm5    = pkt_q[5].kind == MEM_LOAD;
    assign is_st_mm5    = pkt_q[5].kind == MEM_STORE;
    assign is_fl_mm5    = pkt_q[5].kind == MEM_FILL;
    assign req_addr_mm5 = pkt_q[5].addr;
    assign st_set_mm5   = pkt_q[5].addr[L1_SET_HI:L1_SET_LO];
    assign st_way_mm5   = way_mm5;

    always_comb begin
        action_mm5.complete = valid_q[5] & (is_fl_mm5 | (is_ld_mm5 | is_st_mm5) & hit_mm5);
        action_mm5.recycle  = valid_q[5] & ~action_mm5.complete;

        complete_mm5.valid  = action_mm5.complete & ~is_fl_mm5;
        complete_mm5.robid  = pkt_q[5].robid;

        prf_wr_en_mm5       = action_mm5.complete & is_ld_mm5;
        prf_wr_pkt_mm5.pdst = pkt_q[5].pdst;
        prf_wr_pkt_mm5.data = rot_mm5;

        st_wr_en_mm5        = action_mm5.complete & is_st_mm5;
        // Allocate only when no fill for this line is outstanding
        flq_alloc_mm5       = valid_q[5] & (is_ld_mm5 | is_st_mm5) & ~hit_mm5 & ~mat_mm5;
    end

    // Store bytes merged into the line read at MM1
    always_comb begin
        t_cl_offset o;
        o           = pkt_q[5].addr[L1_OFFSET_HI:L1_OFFSET_LO];
        st_line_mm5 = line_mm5;
        for (int b = 0; b < 4; b++) begin
            st_line_mm5.b[o] = pkt_q[5].st_data[8*b +: 8];
            o = o + 1'b1;
        end
    end

endmodule

//--- l1_dcache_top.sv
`timescale 1ns/100ps

module l1_dcache_top import core_pkg::*, mem_pkg::*; #(
    parameter int FLQ_ENTRIES = 2
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              ld_req,
    input  t_mempipe_arb      ld_req_pkt,
    output logic              ld_gnt,
    input  logic              st_req,
    input  t_mempipe_arb      st_req_pkt,
    output logic              st_gnt,

    output logic              valid_mm5,
    output t_mempipe_action   action_mm5,
    output t_rob_complete_pkt complete_mm5,
    output logic              prf_wr_en_mm5,
    output t_prf_wr_pkt       prf_wr_pkt_mm5,

    output logic              wb_cyc,
    output logic              wb_stb,
    output logic [13:0]       wb_adr,
    input  logic              wb_ack,
    input  logic [31:0]       wb_dat_i
);

    // Fill request from the queue
    logic                     fl_req;
    logic                     fl_gnt;
    t_mempipe_arb             fl_req_pkt;

    // Array access
    t_l1_set_addr             set_addr_mm1;
    logic                     rd_en_mm1;
    logic                     fill_en_mm1;
    t_l1_way                  fill_way_mm1;
    t_l1_tag                  fill_tag_mm1;
    t_cl                      fill_line_mm1;
    t_l1_tag [L1_NUM_WAYS-1:0] tag_rd_ways_mm2;
    t_mesi [L1_NUM_WAYS-1:0]  state_rd_ways_mm2;
    t_cl [L1_NUM_WAYS-1:0]    data_rd_ways_mm2;
    logic                     st_wr_en_mm5;
    t_l1_set_addr             st_set_mm5;
    t_l1_way                  st_way_mm5;
    t_cl                      st_line_mm5;

    // Fill-queue lookup and allocation
    logic                     valid_mm1;
    t_mempipe_arb             req_pkt_mm1;
    logic                     flq_addr_mat_mm2;
    logic                     flq_alloc_mm5;
    t_paddr                   req_addr_mm5;

    mempipe u_mempipe (
        .clk, .rst_n,
        .ld_req, .ld_req_pkt, .ld_gnt,
        .st_req, .st_req_pkt, .st_gnt,
        .fl_req, .fl_req_pkt, .fl_gnt,
        .set_addr_mm1, .rd_en_mm1, .fill_en_mm1, .fill_way_mm1, .fill_tag_mm1, .fill_line_mm1,
        .tag_rd_ways_mm2, .state_rd_ways_mm2, .data_rd_ways_mm2,
        .valid_mm1, .req_pkt_mm1, .flq_addr_mat_mm2,
        .st_wr_en_mm5, .st_set_mm5, .st_way_mm5, .st_line_mm5,
        .flq_alloc_mm5, .req_addr_mm5,
        .valid_mm5, .action_mm5, .complete_mm5, .prf_wr_en_mm5, .prf_wr_pkt_mm5
    );

    l1_arrays u_arrays (
        .clk, .rst_n,
        .set_addr_mm1, .rd_en_mm1, .fill_en_mm1, .fill_way_mm1, .fill_tag_mm1, .fill_line_mm1,
        .st_wr_en_mm5, .st_set_mm5, .st_way_mm5, .st_line_mm5,
        .tag_rd_ways_mm2, .state_rd_ways_mm2, .data_rd_ways_mm2
    );

    fill_queue #(
        .FLQ_ENTRIES(FLQ_ENTRIES)
    ) u_fill_queue (
        .clk, .rst_n,
        .valid_mm1, .req_pkt_mm1, .flq_addr_mat_mm2,
        .flq_alloc_mm5, .req_addr_mm5,
        .fl_req, .fl_req_pkt, .fl_gnt,
        .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_dat_i
    );

endmodule

//--- tb_l1_dcache.sv
`timescale 1ns/100ps

module tb_l1_dcache import core_pkg::*, mem_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    // Six short tests of a few hundred cycles, with room for slow acks
    localparam int MAX_CYCLES = 2000;
    localparam logic [31:0] MODEL_XOR = 32'hA5A50000;

    // One MM5 result of a load or store
    typedef struct packed {
        logic         complete;
        logic         recycle;
        logic         cpl_valid;
        t_robid       robid;
        logic         prf_en;
        t_prf_id      pdst;
        t_rv_reg_data data;
    } t_result;

    logic              clk;
    logic              rst_n;
    logic              ld_req;
    t_mempipe_arb      ld_req_pkt;
    logic              ld_gnt;
    logic              st_req;
    t_mempipe_arb      st_req_pkt;
    logic              st_gnt;
    logic              valid_mm5;
    t_mempipe_action   action_mm5;
    t_rob_complete_pkt complete_mm5;
    logic              prf_wr_en_mm5;
    t_prf_wr_pkt       prf_wr_pkt_mm5;
    logic              wb_cyc;
    logic              wb_stb;
    logic [13:0]       wb_adr;
    logic              wb_ack = 1'b0;
    logic [31:0]       wb_dat_i = 32'h0;

    t_result           results [$];
    t_result           mon_res;
    int                fills_seen = 0;
    logic              fill_prf_en;
    logic [13:0]       beat_log [$];
    logic [7:0]        shadow [logic [15:0]];
    logic [31:0]       rng_state = 32'h7bc71edd;
    int                ack_wait = -1;
    int                cycle_cnt = 0;
    int                total_errors;
    int                test_errors;
    int                tests_run;
    int                tests_failed;

    l1_dcache_top #(
        .FLQ_ENTRIES(2)
    ) uut (
        .clk, .rst_n,
        .ld_req, .ld_req_pkt, .ld_gnt,
        .st_req, .st_req_pkt, .st_gnt,
        .valid_mm5, .action_mm5, .complete_mm5, .prf_wr_en_mm5, .prf_wr_pkt_mm5,
        .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_dat_i
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run went past %0d cycles without finishing", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Wishbone slave, acks each beat after 0 to 2 cycles
    always @(negedge clk) begin
        if (!rst_n) begin
            wb_ack   = 1'b0;
            ack_wait = -1;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (ack_wait < 0) begin
                rng_state = next_random(rng_state);
                ack_wait  = int'(rng_state % 3);
            end
            if (ack_wait == 0) begin
                wb_ack   = 1'b1;
                wb_dat_i = {18'd0, wb_adr} ^ MODEL_XOR;
                beat_log.push_back(wb_adr);
                ack_wait = -1;
            end else begin
                ack_wait--;
            end
        end
    end

    // MM5 monitor; a fill completes without a completion packet and is only counted
    always @(negedge clk) begin
        if (rst_n && valid_mm5) begin
            if (action_mm5.recycle || complete_mm5.valid) begin
                mon_res.complete  = action_mm5.complete;
                mon_res.recycle   = action_mm5.recycle;
                mon_res.cpl_valid = complete_mm5.valid;
                mon_res.robid     = complete_mm5.robid;
                mon_res.prf_en    = prf_wr_en_mm5;
                mon_res.pdst      = prf_wr_pkt_mm5.pdst;
                mon_res.data      = prf_wr_pkt_mm5.data;
                results.push_back(mon_res);
            end else if (action_mm5.complete) begin
                fill_prf_en = prf_wr_en_mm5;
                fills_seen++;
            end
        end
    end

    // Memory byte as the model returns it, with stores laid over it
    function automatic logic [7:0] mem_byte(input t_paddr a);
        logic [31:0] word;
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        word = {18'd0, a[15:2]} ^ MODEL_XOR;
        return word[8*a[1:0] +: 8];
    endfunction

    function automatic t_rv_reg_data load_value(input t_paddr a);
        t_rv_reg_data v;
        t_cl_offset   o;
        o = a[3:0];
        for (int b = 0; b < 4; b++) begin
            v[8*b +: 8] = mem_byte({a[15:4], o});
            o = o + 4'd1;
        end
        return v;
    endfunction

    task automatic write_shadow(input t_paddr a, input t_rv_reg_data data);
        t_cl_offset o;
        o = a[3:0];
        for (int b = 0; b < 4; b++) begin
            shadow[{a[15:4], o}] = data[8*b +: 8];
            o = o + 4'd1;
        end
    endtask

    function automatic t_mempipe_arb make_pkt(input t_mem_kind kind, input t_paddr addr,
                                              input t_rv_reg_data data, input t_robid robid,
                                              input t_prf_id pdst);
        t_mempipe_arb p;
        p         = '0;
        p.kind    = kind;
        p.addr    = addr;
        p.st_data = data;
        p.robid   = robid;
        p.pdst    = pdst;
        return p;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            test_errors++;
            total_errors++;
        end
    endtask

    // Hold the request from a falling edge until a grant is seen
    task automatic send_req(input t_mem_kind kind, input t_paddr addr, input t_rv_reg_data data,
                            input t_robid robid, input t_prf_id pdst);
        logic granted;
        granted = 1'b0;
        @(negedge clk);
        if (kind == MEM_STORE) begin
            st_req_pkt = make_pkt(kind, addr, data, robid, pdst);
            st_req     = 1'b1;
        end else begin
            ld_req_pkt = make_pkt(kind, addr, data, robid, pdst);
            ld_req     = 1'b1;
        end
        while (!granted) begin
            #(CLK_PERIOD/4);
            granted = (kind == MEM_STORE) ? st_gnt : ld_gnt;
            @(negedge clk);
        end
        ld_req = 1'b0;
        st_req = 1'b0;
    endtask

    task automatic take_result(output t_result r);
        while (results.size() == 0) begin
            @(negedge clk);
        end
        r = results.pop_front();
    endtask

    task automatic check_miss(input t_result r, input t_robid robid);
        check_val("action_mm5.recycle", r.recycle, 1'b1);
        check_val("complete_mm5.valid", r.cpl_valid, 1'b0);
        check_val("prf_wr_en_mm5", r.prf_en, 1'b0);
        check_val("complete_mm5.robid", r.robid, robid);
    endtask

    task automatic check_hit(input t_result r, input t_robid robid, input logic wr_en,
                             input t_prf_id pdst, input t_rv_reg_data data);
        check_val("action_mm5.complete", r.complete, 1'b1);
        check_val("complete_mm5.valid", r.cpl_valid, 1'b1);
        check_val("complete_mm5.robid", r.robid, robid);
        check_val("prf_wr_en_mm5", r.prf_en, wr_en);
        if (wr_en) begin
            check_val("prf_wr_pkt_mm5.pdst", r.pdst, pdst);
            check_val("prf_wr_pkt_mm5.data", r.data, data);
        end
    endtask

    task automatic expect_recycle(input t_mem_kind kind, input t_paddr addr,
                                  input t_robid robid);
        t_result r;
        send_req(kind, addr, 32'h0, robid, 6'd0);
        take_result(r);
        check_miss(r, robid);
    endtask

    task automatic expect_load_hit(input t_paddr addr, input t_robid robid, input t_prf_id pdst);
        t_result r;
        send_req(MEM_LOAD, addr, 32'h0, robid, pdst);
        take_result(r);
        check_hit(r, robid, 1'b1, pdst, load_value(addr));
    endtask

    task automatic expect_store_hit(input t_paddr addr, input t_rv_reg_data data,
                                    input t_robid robid);
        t_result r;
        send_req(MEM_STORE, addr, data, robid, 6'd0);
        take_result(r);
        check_hit(r, robid, 1'b0, 6'd0, 32'h0);
        write_shadow(addr, data);
    endtask

    // One line read of 4 ascending word beats, then the fill reaching MM5
    task automatic wait_fill(input t_paddr line);
        int fills_before;
        while (beat_log.size() < 4) begin
            @(negedge clk);
        end
        fills_before = fills_seen;
        while (fills_seen == fills_before) begin
            @(negedge clk);
        end
        check_val("prf_wr_en_mm5", fill_prf_en, 1'b0);
        check_val("wishbone beat count", beat_log.size(), 4);
        for (int k = 0; k < 4 && k < beat_log.size(); k++) begin
            check_val("wb_adr", beat_log[k], {line[15:4], 2'(k)});
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("[%s] ok", name);
        end else begin
            tests_failed++;
            $display("[%s] %0d error(s)", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic reset_state();
        check_val("valid_mm5", valid_mm5, 1'b0);
        check_val("wb_cyc", wb_cyc, 1'b0);
        check_val("wb_stb", wb_stb, 1'b0);
        check_val("ld_gnt", ld_gnt, 1'b0);
        check_val("st_gnt", st_gnt, 1'b0);
        check_val("complete_mm5.valid", complete_mm5.valid, 1'b0);
        check_val("prf_wr_en_mm5", prf_wr_en_mm5, 1'b0);
        beat_log.delete();
        expect_recycle(MEM_LOAD, 16'h0120, 6'd1);
        wait_fill(16'h0120);
        finish_test("reset");
    endtask

    task automatic miss_fill_retry();
        beat_log.delete();
        expect_recycle(MEM_LOAD, 16'h0255, 6'd2);
        wait_fill(16'h0250);
        expect_load_hit(16'h0255, 6'd2, 6'd9);
        check_val("wishbone beat count", beat_log.size(), 4);
        finish_test("miss_fill_retry");
    endtask

    task automatic wrap_rotate();
        expect_load_hit(16'h012d, 6'd4, 6'd10);
        expect_load_hit(16'h012e, 6'd5, 6'd11);
        expect_load_hit(16'h012f, 6'd6, 6'd12);
        finish_test("wrap_rotate");
    endtask

    task automatic store_after_fill();
        beat_log.delete();
        expect_recycle(MEM_STORE, 16'h0338, 6'd7);
        wait_fill(16'h0330);
        expect_store_hit(16'h0338, 32'h11223344, 6'd7);
        expect_load_hit(16'h0336, 6'd8, 6'd13);
        // Store bytes that wrap past the end of the line
        expect_store_hit(16'h033e, 32'h55667788, 6'd9);
        expect_load_hit(16'h033c, 6'd10, 6'd14);
        finish_test("store_after_fill");
    endtask

    task automatic duplicate_miss();
        t_result r;
        logic    gnt_a;
        logic    gnt_b;
        beat_log.delete();
        @(negedge clk);
        ld_req_pkt = make_pkt(MEM_LOAD, 16'h0404, 32'h0, 6'd11, 6'd15);
        ld_req     = 1'b1;
        #(CLK_PERIOD/4);
        gnt_a = ld_gnt;
        @(negedge clk);
        ld_req_pkt = make_pkt(MEM_LOAD, 16'h0408, 32'h0, 6'd12, 6'd16);
        #(CLK_PERIOD/4);
        gnt_b = ld_gnt;
        @(negedge clk);
        ld_req = 1'b0;
        check_val("ld_gnt", gnt_a, 1'b1);
        check_val("ld_gnt", gnt_b, 1'b1);
        take_result(r);
        check_miss(r, 6'd11);
        take_result(r);
        check_miss(r, 6'd12);
        wait_fill(16'h0400);
        expect_load_hit(16'h0408, 6'd12, 6'd16);
        check_val("wishbone beat count", beat_log.size(), 4);
        finish_test("duplicate_miss");
    endtask

    task automatic arbitration_order();
        t_result      r;
        t_rv_reg_data ld_exp;
        ld_exp = load_value(16'h0122);
        @(negedge clk);
        ld_req_pkt = make_pkt(MEM_LOAD, 16'h0122, 32'h0, 6'd20, 6'd21);
        st_req_pkt = make_pkt(MEM_STORE, 16'h0334, 32'hcafef00d, 6'd22, 6'd0);
        ld_req     = 1'b1;
        st_req     = 1'b1;
        #(CLK_PERIOD/4);
        check_val("ld_gnt", ld_gnt, 1'b1);
        check_val("st_gnt", st_gnt, 1'b0);
        @(negedge clk);
        ld_req = 1'b0;
        #(CLK_PERIOD/4);
        check_val("st_gnt", st_gnt, 1'b1);
        @(negedge clk);
        st_req = 1'b0;
        write_shadow(16'h0334, 32'hcafef00d);
        take_result(r);
        check_hit(r, 6'd20, 1'b1, 6'd21, ld_exp);
        take_result(r);
        check_hit(r, 6'd22, 1'b0, 6'd0, 32'h0);
        expect_load_hit(16'h0334, 6'd23, 6'd24);
        finish_test("arbitration_order");
    endtask

    initial begin
        rst_n        = 1'b0;
        ld_req       = 1'b0;
        st_req       = 1'b0;
        ld_req_pkt   = '0;
        st_req_pkt   = '0;
        total_errors = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        reset_state();
        miss_fill_retry();
        wrap_rotate();
        store_after_fill();
        duplicate_miss();
        arbitration_order();

        $display("tests run: %0d, tests failing: %0d, checks failing: %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
core_pkg.sv
mem_pkg.sv
l1_arrays.sv
fill_queue.sv
mempipe.sv
l1_dcache_top.sv
tb_l1_dcache.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module tb_l1_dcache -f sources.f -o tb_l1_dcache \
    && ./obj_dir/tb_l1_dcache | tee /dev/stderr | grep -q "^TEST OK$" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
